/* vcrop_config.svh */
/*
 * Build-time constants for the video crop and timing block.
 * Counter width, crop step sizes, forced-blank margins and the
 * keyboard event type and scancodes live here. Include it in
 * any file that needs one of these values.
 */
`ifndef VCROP_CONFIG_SVH
`define VCROP_CONFIG_SVH

`define VCROP_CNT_W        12     // width of every counter and geometry value
`define VCROP_HSTEP        4      // pixels per left/right press
`define VCROP_VSTEP        1      // lines per up/down press
`define VCROP_HFORCE       8      // forced hblank margin at both line ends
`define VCROP_VFORCE_END   3      // forced vblank lines before frame end

`define VCROP_KEY_TYPE     2'd3   // kbd_type of a keyboard event
`define VCROP_KEY_BKSP     8'h41
`define VCROP_KEY_UP       8'h4C
`define VCROP_KEY_DOWN     8'h4D
`define VCROP_KEY_LEFT     8'h4F
`define VCROP_KEY_RIGHT    8'h4E
`define VCROP_KEY_ALT_L    8'h64
`define VCROP_KEY_ALT_R    8'h65
`define VCROP_KEY_ALT_L_REL 8'hE4
`define VCROP_KEY_ALT_R_REL 8'hE5

`endif

/* vcrop_pkg.sv */
/*
 * Shared types for the video crop block.
 * Geometry count type, the decoded key command enum and the
 * packed structs that carry the core's sync levels, the four
 * crop edges and the per-frame screen info snapshot.
 */
`include "vcrop_config.svh"

package vcrop_pkg;

	typedef logic [`VCROP_CNT_W-1:0] cnt_t;

	typedef enum logic [2:0] {
		cmd_none,
		cmd_clear,
		cmd_up,
		cmd_down,
		cmd_left,
		cmd_right,
		cmd_alt_on,
		cmd_alt_off
	} key_cmd_e;

	typedef struct packed {
		logic hs_n;     // active low
		logic vs_n;     // active low
		logic hblank;   // core's own blanking
		logic vblank;
		logic field1;   // odd field of interlace
	} video_sync_t;

	typedef struct packed {
		cnt_t hbl_l;
		cnt_t hbl_r;
		cnt_t vbl_t;
		cnt_t vbl_b;
	} crop_t;

	typedef struct packed {
		crop_t      crop;
		cnt_t       hsize;
		cnt_t       vsize;
		logic [1:0] res;
		logic [6:0] flg;    // change counter
	} screen_info_t;

endpackage

/* crop_key_ctrl.sv */
/*
 * Crop edge control from keyboard scancodes.
 * A keyboard event is any change of kms_level while kbd_type marks
 * a key. Arrows move the top/left edges, or bottom/right with alt
 * held; backspace clears all edges. sset loads a full preset and
 * takes priority over a key in the same cycle.
 */
`timescale 1ns/1ps
`include "vcrop_config.svh"

module crop_key_ctrl (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              kms_level,
	input  logic [1:0]        kbd_type,
	input  logic [7:0]        kbd_data,
	input  logic              sset,
	input  vcrop_pkg::crop_t  preset,
	output vcrop_pkg::crop_t  crop
);

	localparam vcrop_pkg::cnt_t hstep = `VCROP_HSTEP;
	localparam vcrop_pkg::cnt_t vstep = `VCROP_VSTEP;

	logic                old_level;
	logic                alt;
	logic                key_evt;
	vcrop_pkg::key_cmd_e cmd;

	assign key_evt = (old_level ^ kms_level) && (kbd_type == `VCROP_KEY_TYPE);

	always_comb begin
		case (kbd_data)
			`VCROP_KEY_BKSP:  cmd = vcrop_pkg::cmd_clear;
			`VCROP_KEY_UP:    cmd = vcrop_pkg::cmd_up;
			`VCROP_KEY_DOWN:  cmd = vcrop_pkg::cmd_down;
			`VCROP_KEY_LEFT:  cmd = vcrop_pkg::cmd_left;
			`VCROP_KEY_RIGHT: cmd = vcrop_pkg::cmd_right;
			`VCROP_KEY_ALT_L,
			`VCROP_KEY_ALT_R: cmd = vcrop_pkg::cmd_alt_on;
			`VCROP_KEY_ALT_L_REL,
			`VCROP_KEY_ALT_R_REL: cmd = vcrop_pkg::cmd_alt_off;
			default:          cmd = vcrop_pkg::cmd_none;
		endcase
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_level <= 1'b0;
			alt <= 1'b0;
			crop <= '0;
		end else begin
			old_level <= kms_level;
			if (key_evt) begin
				case (cmd)
					vcrop_pkg::cmd_clear: crop <= '0;
					vcrop_pkg::cmd_up: begin
						if (alt) crop.vbl_b <= crop.vbl_b + vstep;
						else     crop.vbl_t <= crop.vbl_t + vstep;
					end
					vcrop_pkg::cmd_down: begin
						if (alt) crop.vbl_b <= crop.vbl_b - vstep;   // wraps mod 2^12
						else     crop.vbl_t <= crop.vbl_t - vstep;
					end
					vcrop_pkg::cmd_left: begin
						if (alt) crop.hbl_r <= crop.hbl_r + hstep;
						else     crop.hbl_l <= crop.hbl_l + hstep;
					end
					vcrop_pkg::cmd_right: begin
						if (alt) crop.hbl_r <= crop.hbl_r - hstep;
						else     crop.hbl_l <= crop.hbl_l - hstep;
					end
					vcrop_pkg::cmd_alt_on:  alt <= 1'b1;
					vcrop_pkg::cmd_alt_off: alt <= 1'b0;
					default: ;
				endcase
			end
			if (sset)
				crop <= preset;   // preset beats a key press
		end
	end

endmodule

/* hblank_gen.sv */
/*
 * Horizontal timing measurement and cropped horizontal blank.
 * Measures blank end, blank start and line length from the core's
 * hblank and hsync, then builds a soft blank offset by the crop
 * edges and a forced blank near the sync. hde is the registered
 * inverse of the combined blank.
 */
`timescale 1ns/1ps
`include "vcrop_config.svh"

module hblank_gen (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  vcrop_pkg::video_sync_t sync,
	input  vcrop_pkg::crop_t       crop,
	input  logic                   size_line,
	output logic                   hbl,
	output logic                   hde,
	output vcrop_pkg::cnt_t        hsize
);

	localparam vcrop_pkg::cnt_t soft_lead = 2;   // soft edges land two counts early
	localparam vcrop_pkg::cnt_t force_gap = `VCROP_HFORCE;

	vcrop_pkg::cnt_t hcnt;
	vcrop_pkg::cnt_t hsta, hend, hmax;
	vcrop_pkg::cnt_t shbl_off, shbl_on, fhbl_on;
	logic            old_hs, old_hblank;
	logic            shbl, fhbl;
	logic            hblank_rise, hblank_fall, hs_fall;

	assign hblank_rise = ~old_hblank & sync.hblank;
	assign hblank_fall = old_hblank & ~sync.hblank;
	assign hs_fall     = old_hs & ~sync.hs_n;

	assign shbl_off = hend + crop.hbl_l - soft_lead;
	assign shbl_on  = hsta + crop.hbl_r - soft_lead;
	assign fhbl_on  = hmax - force_gap;

	assign hbl = fhbl | shbl | ~sync.hs_n;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs <= 1'b1;
			old_hblank <= 1'b1;
			hcnt <= '0;
			shbl <= 1'b1;
			fhbl <= 1'b1;   // keeps hde low out of reset
			hde <= 1'b0;
		end else begin
			old_hs <= sync.hs_n;
			old_hblank <= sync.hblank;

			if (!sync.hs_n) hcnt <= '0;
			else            hcnt <= hcnt + 1'b1;

			if (hcnt == shbl_off) shbl <= 1'b0;
			if (hcnt == shbl_on)  shbl <= 1'b1;

			if (hcnt == force_gap) fhbl <= 1'b0;
			if (hcnt == fhbl_on)   fhbl <= 1'b1;

			hde <= ~hbl;
		end
	end

	// geometry of the last line
	always_ff @(posedge clk_sys) begin
		if (hblank_fall) hend <= hcnt;
		if (hblank_rise) hsta <= hcnt;
		if (hs_fall)     hmax <= hcnt;
		if (hblank_rise && size_line)
			hsize <= hcnt - hend;   // visible width
	end

endmodule

/* vblank_gen.sv */
/*
 * Vertical timing measurement and cropped vertical blank.
 * Counts lines on hsync, records blank edges and frame length in
 * field 0 and adds the field 1 height for interlaced modes. The
 * soft and forced vertical blanks are evaluated once per line at
 * the end of the combined horizontal blank.
 */
`timescale 1ns/1ps
`include "vcrop_config.svh"

module vblank_gen (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  vcrop_pkg::video_sync_t sync,
	input  vcrop_pkg::crop_t       crop,
	input  logic                   hbl,
	output logic                   vde,
	output logic                   size_line,
	output logic                   frame_start,
	output vcrop_pkg::cnt_t        vsize
);

	localparam vcrop_pkg::cnt_t one       = 1;
	localparam vcrop_pkg::cnt_t force_gap = `VCROP_VFORCE_END;

	vcrop_pkg::cnt_t vcnt;
	vcrop_pkg::cnt_t vsta, vend, vmax;
	vcrop_pkg::cnt_t f1_vend, f1_vsize;
	vcrop_pkg::cnt_t svbl_off, svbl_on, fvbl_on;
	logic            old_vs, old_hs, old_vblank, old_hbl;
	logic            svbl, fvbl;
	logic            vblank;
	logic            vblank_rise, vblank_fall, vs_fall, hs_fall, hbl_fall;

	assign vblank = sync.vblank | ~sync.vs_n;

	assign vblank_rise = ~old_vblank & vblank;
	assign vblank_fall = old_vblank & ~vblank;
	assign vs_fall     = old_vs & ~sync.vs_n;
	assign hs_fall     = old_hs & ~sync.hs_n;
	assign hbl_fall    = old_hbl & ~hbl;

	assign svbl_off = vend + crop.vbl_t - one;
	assign svbl_on  = vsta + crop.vbl_b - one;
	assign fvbl_on  = vmax - force_gap;

	assign frame_start = vblank_fall;
	assign size_line   = ~sync.field1 & (vcnt == vsta + one);   // first line after active area
	assign vde         = ~(fvbl | svbl);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_vs <= 1'b1;
			old_hs <= 1'b1;
			old_vblank <= 1'b1;
			old_hbl <= 1'b1;
			vcnt <= '0;
			f1_vsize <= '0;
			svbl <= 1'b1;
			fvbl <= 1'b1;
		end else begin
			old_vs <= sync.vs_n;
			old_hs <= sync.hs_n;
			old_vblank <= vblank;
			old_hbl <= hbl;

			if (hs_fall)     vcnt <= vcnt + 1'b1;
			if (!sync.vs_n)  vcnt <= '0;

			if (vblank_rise) begin
				if (sync.field1) f1_vsize <= vcnt - f1_vend;
				else             f1_vsize <= '0;   // consumed by vsize below
			end

			if (hbl_fall) begin
				if (vcnt == svbl_off) svbl <= 1'b0;
				if (vcnt == svbl_on)  svbl <= 1'b1;
				if (vcnt == one)      fvbl <= 1'b0;
				if (vcnt == fvbl_on)  fvbl <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!sync.field1) begin
			if (vblank_fall) vend <= vcnt;
			if (vblank_rise) vsta <= vcnt;
			if (vs_fall)     vmax <= vcnt;
			if (vblank_rise)
				vsize <= vcnt - vend + f1_vsize;   // both fields together
		end else begin
			if (vblank_fall) f1_vend <= vcnt;
		end
	end

endmodule

/* screen_info.sv */
/*
 * Per-frame snapshot of crop and measured geometry.
 * Captured on each frame start; flg steps whenever the resolution
 * code or the visible size differs from the previous snapshot.
 */
`timescale 1ns/1ps

module screen_info (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    frame_start,
	input  vcrop_pkg::crop_t        crop,
	input  vcrop_pkg::cnt_t         hsize,
	input  vcrop_pkg::cnt_t         vsize,
	input  logic [1:0]              res,
	output vcrop_pkg::screen_info_t info
);

	logic changed;

	assign changed = (info.res != res) ||
	                 (info.hsize != hsize) ||
	                 (info.vsize != vsize);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			info <= '0;
		end else if (frame_start) begin
			info.crop <= crop;
			info.hsize <= hsize;
			info.vsize <= vsize;
			info.res <= res;
			if (changed)
				info.flg <= info.flg + 1'b1;   // wraps at 128
		end
	end

endmodule

/* vcrop_top.sv */
/*
 * Top level of the video crop and timing measurement block.
 * Connects the key decoder, the two blank generators and the
 * screen info snapshot. Everything runs on clk_sys.
 */
`timescale 1ns/1ps

module vcrop_top (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  vcrop_pkg::video_sync_t  sync,
	input  logic [1:0]              res,
	input  logic                    kms_level,
	input  logic [1:0]              kbd_type,
	input  logic [7:0]              kbd_data,
	input  logic                    sset,
	input  vcrop_pkg::crop_t        preset,
	output logic                    hde,
	output logic                    vde,
	output vcrop_pkg::cnt_t         hsize,
	output vcrop_pkg::cnt_t         vsize,
	output vcrop_pkg::screen_info_t info
);

	vcrop_pkg::crop_t crop;
	logic             hbl;
	logic             size_line;
	logic             frame_start;

	crop_key_ctrl crop_key_ctrl_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.kms_level (kms_level),
		.kbd_type  (kbd_type),
		.kbd_data  (kbd_data),
		.sset      (sset),
		.preset    (preset),
		.crop      (crop)
	);

	hblank_gen hblank_gen_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.sync      (sync),
		.crop      (crop),
		.size_line (size_line),
		.hbl       (hbl),
		.hde       (hde),
		.hsize     (hsize)
	);

	vblank_gen vblank_gen_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.sync        (sync),
		.crop        (crop),
		.hbl         (hbl),
		.vde         (vde),
		.size_line   (size_line),
		.frame_start (frame_start),
		.vsize       (vsize)
	);

	screen_info screen_info_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.frame_start (frame_start),
		.crop        (crop),
		.hsize       (hsize),
		.vsize       (vsize),
		.res         (res),
		.info        (info)
	);

endmodule

/* tb_vcrop.sv */
/*
 * Testbench for the video crop and timing block.
 * Generates a fixed progressive video timing, presses crop keys,
 * loads a preset and changes the resolution code, then compares
 * hde/vde widths and the screen info against a reference model.
 */
`timescale 1ns/1ps
`include "vcrop_config.svh"

module tb_vcrop;

	localparam int line_len = 200;
	localparam int frame_lines = 40;
	localparam int total_frames = 12;
	localparam int limit_cycles = total_frames * frame_lines * line_len + 1000;

	logic                    clk_sys;
	logic                    reset;
	vcrop_pkg::video_sync_t  sync;
	logic [1:0]              res;
	logic                    kms_level;
	logic [1:0]              kbd_type;
	logic [7:0]              kbd_data;
	logic                    sset;
	vcrop_pkg::crop_t        preset;
	logic                    hde;
	logic                    vde;
	vcrop_pkg::cnt_t         hsize;
	vcrop_pkg::cnt_t         vsize;
	vcrop_pkg::screen_info_t info;

	int errors = 0;
	int checks = 0;
	int frame_cnt = 0;
	int last_width = 0;
	int last_lines = 0;
	logic [31:0] lfsr_state = 32'h196e_626c;
	int model_l = 0;
	int model_r = 0;
	int model_t = 0;
	int model_b = 0;

	vcrop_top vcrop_top_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.sync      (sync),
		.res       (res),
		.kms_level (kms_level),
		.kbd_type  (kbd_type),
		.kbd_data  (kbd_data),
		.sset      (sset),
		.preset    (preset),
		.hde       (hde),
		.vde       (vde),
		.hsize     (hsize),
		.vsize     (vsize),
		.info      (info)
	);

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int val);
		int i;
		val = 0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = (val << 1) | int'(lfsr_state[0]);
		end
	endtask

	// hde cycles per line from soft window 29+l..158+r in source counts and forced 19..192
	function automatic int expected_width(input int l, input int r);
		int lo;
		int hi;
		lo = (29 + l > `VCROP_HFORCE + 11) ? 29 + l : `VCROP_HFORCE + 11;
		hi = (158 + r < line_len - `VCROP_HFORCE) ? 158 + r : line_len - `VCROP_HFORCE;
		expected_width = (hi >= lo) ? hi - lo + 1 : 0;
	endfunction

	// visible lines within soft 4+t..31+b and forced 2..35 as the line counter lags vsync
	function automatic int expected_lines(input int t, input int b);
		int lo;
		int hi;
		lo = (4 + t > 2) ? 4 + t : 2;
		hi = (31 + b < frame_lines - `VCROP_VFORCE_END - 2) ? 31 + b :
		     frame_lines - `VCROP_VFORCE_END - 2;
		expected_lines = (hi >= lo) ? hi - lo + 1 : 0;
	endfunction

	task automatic check_val(input int got, input int exp, input string msg);
		checks++;
		if (got != exp) begin
			errors++;
			$display("mismatch at %0t ns: %s got %0d expected %0d", $time, msg, got, exp);
		end
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frame_cnt + n;
		wait (frame_cnt >= target);
	endtask

	task automatic press_key(input logic [7:0] code);
		@(negedge clk_sys);
		kbd_type = `VCROP_KEY_TYPE;
		kbd_data = code;
		kms_level = ~kms_level;   // toggling level marks the event
		@(negedge clk_sys);
		kbd_type = 2'd0;
	endtask

	task automatic press_many(input logic [7:0] code, input int n);
		int i;
		for (i = 0; i < n; i++)
			press_key(code);
	endtask

	// video source that also counts hde per line and visible lines per frame
	initial begin
		int line;
		int col;
		int width_acc;
		int lines_acc;
		logic line_hit;
		line = frame_lines - 1;
		col = line_len - 1;
		width_acc = 0;
		lines_acc = 0;
		line_hit = 1'b0;
		sync = 5'b11110;   // in blank, sync inactive
		forever begin
			@(negedge clk_sys);
			col++;
			if (col == line_len) begin
				col = 0;
				line = (line == frame_lines - 1) ? 0 : line + 1;
			end
			if (hde) width_acc++;   // sample belongs to the new position
			if (hde && vde) line_hit = 1'b1;
			if (col == line_len - 1) begin
				if (line == 20) last_width = width_acc;
				if (line_hit) lines_acc++;
				width_acc = 0;
				line_hit = 1'b0;
				if (line == frame_lines - 1) begin
					last_lines = lines_acc;
					lines_acc = 0;
					frame_cnt++;
				end
			end
			sync.hs_n = (col >= 10);
			sync.hblank = (col >= 160) || (col < 30);
			sync.vs_n = (line >= 2);
			sync.vblank = !((line >= 6) && (line <= 33));
			sync.field1 = 1'b0;
		end
	end

	initial begin
		repeat (limit_cycles) @(posedge clk_sys);
		$display("timeout: the run did not finish within %0d cycles", limit_cycles);
		$display("Test failed");
		$finish;
	end

	initial begin
		int n_a;
		int n_b;
		int rnd;
		int flg0;
		reset = 1'b1;
		res = 2'd0;
		kms_level = 1'b0;
		kbd_type = 2'd0;
		kbd_data = 8'h00;
		sset = 1'b0;
		preset = '0;
		repeat (2) @(negedge clk_sys);
		reset = 1'b0;

		// measured geometry with no crop
		wait_frames(3);
		check_val(int'(hsize), 130, "hsize");
		check_val(int'(vsize), 28, "vsize");
		check_val(int'(info.hsize), 130, "info hsize");
		check_val(int'(info.vsize), 28, "info vsize");
		check_val(last_width, expected_width(0, 0), "hde width, no crop");
		check_val(last_lines, expected_lines(0, 0), "vde lines, no crop");

		// horizontal edges
		take_bits(3, n_a);
		take_bits(2, n_b);
		n_a = n_a + 4;   // net move is never zero
		press_many(`VCROP_KEY_LEFT, n_a);
		press_many(`VCROP_KEY_RIGHT, n_b);
		model_l = `VCROP_HSTEP * (n_a - n_b);
		take_bits(3, n_a);
		take_bits(2, n_b);
		n_a = n_a + 4;
		press_key(`VCROP_KEY_ALT_L);
		press_many(`VCROP_KEY_LEFT, n_a);
		press_many(`VCROP_KEY_RIGHT, n_b);
		press_key(`VCROP_KEY_ALT_L_REL);
		model_r = `VCROP_HSTEP * (n_a - n_b);
		wait_frames(2);
		check_val(last_width, expected_width(model_l, model_r), "hde width after crop");

		// vertical edges
		take_bits(3, n_a);
		take_bits(1, n_b);
		n_a = n_a + 3;   // at least one down and a net move up
		n_b = n_b + 1;
		press_many(`VCROP_KEY_UP, n_a);
		press_many(`VCROP_KEY_DOWN, n_b);
		model_t = `VCROP_VSTEP * (n_a - n_b);
		take_bits(3, n_a);
		take_bits(1, n_b);
		n_a = n_a + 3;
		n_b = n_b + 1;
		press_key(`VCROP_KEY_ALT_R);
		press_many(`VCROP_KEY_UP, n_a);
		press_many(`VCROP_KEY_DOWN, n_b);
		press_key(`VCROP_KEY_ALT_R_REL);
		model_b = `VCROP_VSTEP * (n_a - n_b);
		wait_frames(2);
		check_val(last_lines, expected_lines(model_t, model_b), "vde lines after crop");
		check_val(last_width, expected_width(model_l, model_r), "hde width unchanged");

		// clear, then preset load
		press_key(`VCROP_KEY_BKSP);
		wait_frames(2);
		check_val(last_width, expected_width(0, 0), "hde width after clear");
		check_val(last_lines, expected_lines(0, 0), "vde lines after clear");
		check_val(int'(info.crop.hbl_l), 0, "info hbl_l after clear");
		check_val(int'(info.crop.vbl_b), 0, "info vbl_b after clear");
		take_bits(12, rnd);
		preset.hbl_l = rnd[11:0];
		take_bits(12, rnd);
		preset.hbl_r = rnd[11:0];
		take_bits(12, rnd);
		preset.vbl_t = rnd[11:0];
		take_bits(12, rnd);
		preset.vbl_b = rnd[11:0];
		@(negedge clk_sys);
		sset = 1'b1;
		@(negedge clk_sys);
		sset = 1'b0;
		wait_frames(1);
		check_val(int'(info.crop.hbl_l), int'(preset.hbl_l), "info hbl_l preset");
		check_val(int'(info.crop.hbl_r), int'(preset.hbl_r), "info hbl_r preset");
		check_val(int'(info.crop.vbl_t), int'(preset.vbl_t), "info vbl_t preset");
		check_val(int'(info.crop.vbl_b), int'(preset.vbl_b), "info vbl_b preset");

		// resolution change counter
		flg0 = int'(info.flg);
		res = 2'd2;
		wait_frames(1);
		check_val(int'(info.res), 2, "info res");
		check_val(int'(info.flg), (flg0 + 1) % 128, "info flg after res change");
		wait_frames(1);
		check_val(int'(info.flg), (flg0 + 1) % 128, "info flg steady frame");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* sim.f */
+incdir+.
vcrop_pkg.sv
crop_key_ctrl.sv
hblank_gen.sv
vblank_gen.sv
screen_info.sv
vcrop_top.sv
tb_vcrop.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = tb_vcrop
FILELIST  = sim.f
BUILD     = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	@out=$$(./$(BUILD)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf $(BUILD)
